// ==== rtl/aluPkg.sv ====
package aluPkg;

  // command codes seen by the requester
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    XOR  = 3'd2,
    SLT  = 3'd3,
    AND  = 3'd4,
    NAND = 3'd5,
    NOR  = 3'd6,
    OR   = 3'd7
  } aluCmdT;

  // three bits hold the five result sources
  typedef enum logic [2:0] {
    selAdd = 3'd0,
    selXor = 3'd1,
    selSlt = 3'd2,
    selAnd = 3'd3,
    selOr  = 3'd4
  } resultSelT;

  localparam int DEFAULT_WIDTH = 32;  // default datapath width

  typedef logic [DEFAULT_WIDTH-1:0] wordT;

endpackage

// ==== rtl/seqPkg.sv ====
package seqPkg;

  // request/acknowledge server states
  typedef enum logic [1:0] {
    idle    = 2'd0,  // waiting for req
    compute = 2'd1,  // operands captured and core settling
    done    = 2'd2   // ack high until req drops
  } serverStateT;

  // carryOut, overflow, zero
  localparam int FLAG_BITS = 3;

endpackage

// ==== rtl/aluControl.sv ====
`timescale 1ns/1ps

module aluControl import aluPkg::*; (
  input  aluCmdT    cmd,
  output resultSelT resultSel,
  output logic      invertA,
  output logic      invertB,
  output logic      carryIn,
  output logic      enableOverflow
);

  always_comb begin
    resultSel      = selAdd;
    invertA        = 1'b0;
    invertB        = 1'b0;
    carryIn        = 1'b0;
    enableOverflow = 1'b0;
    case (cmd)
      ADD: begin
        enableOverflow = 1'b1;
      end
      SUB: begin
        invertB        = 1'b1;  // a + ~b + 1
        carryIn        = 1'b1;
        enableOverflow = 1'b1;
      end
      SLT: begin
        resultSel = selSlt;
        invertB   = 1'b1;  // subtract with flags masked
        carryIn   = 1'b1;
      end
      XOR:  resultSel = selXor;
      AND:  resultSel = selAnd;
      NOR: begin
        resultSel = selAnd;  // ~a & ~b
        invertA   = 1'b1;
        invertB   = 1'b1;
      end
      OR:   resultSel = selOr;
      NAND: begin
        resultSel = selOr;  // ~a | ~b
        invertA   = 1'b1;
        invertB   = 1'b1;
      end
      default: resultSel = selAdd;
    endcase
  end

endmodule

// ==== rtl/rippleAdder.sv ====
`timescale 1ns/1ps

module rippleAdder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             carryIn,
  output logic [WIDTH-1:0] sum,
  output logic             carryOut,
  output logic             overflow
);

  logic [WIDTH:0] carry;  // carry[i] feeds bit i

  assign carry[0] = carryIn;

  // one full-adder cell per bit
  genvar i;
  generate
    for (i = 0; i < WIDTH; i++) begin : genCell
      logic halfSum;

      assign halfSum      = a[i] ^ b[i];
      assign sum[i]       = halfSum ^ carry[i];
      assign carry[i + 1] = (a[i] & b[i]) | (halfSum & carry[i]);
    end
  endgenerate

  assign carryOut = carry[WIDTH];

  // signed overflow when carry into the sign bit differs from carry out of it
  assign overflow = carry[WIDTH] ^ carry[WIDTH-1];

endmodule

// ==== rtl/aluCore.sv ====
`timescale 1ns/1ps

module aluCore import aluPkg::*; #(
  parameter int WIDTH = 32
) (
  input  aluCmdT           cmd,
  input  logic [WIDTH-1:0] operandA,
  input  logic [WIDTH-1:0] operandB,
  output logic [WIDTH-1:0] result,
  output logic             carryOut,
  output logic             overflow,
  output logic             zero
);

  resultSelT        resultSel;
  logic             invertA;
  logic             invertB;
  logic             carryIn;
  logic             enableOverflow;
  logic [WIDTH-1:0] flipA;
  logic [WIDTH-1:0] flipB;
  logic [WIDTH-1:0] andResult;
  logic [WIDTH-1:0] orResult;
  logic [WIDTH-1:0] xorResult;
  logic [WIDTH-1:0] addResult;
  logic [WIDTH-1:0] sltResult;
  logic             addCarry;
  logic             addOverflow;

  aluControl control (
    .cmd           (cmd),
    .resultSel     (resultSel),
    .invertA       (invertA),
    .invertB       (invertB),
    .carryIn       (carryIn),
    .enableOverflow(enableOverflow)
  );

  assign flipA = operandA ^ {WIDTH{invertA}};
  assign flipB = operandB ^ {WIDTH{invertB}};

  // inverted operands turn and/or into nor/nand
  assign andResult = flipA & flipB;
  assign orResult  = flipA | flipB;
  assign xorResult = flipA ^ flipB;

  rippleAdder #(.WIDTH(WIDTH)) adder (
    .a       (operandA),
    .b       (flipB),
    .carryIn (carryIn),
    .sum     (addResult),
    .carryOut(addCarry),
    .overflow(addOverflow)
  );

  // sign of a - b corrected for overflow
  assign sltResult = {{(WIDTH-1){1'b0}}, addResult[WIDTH-1] ^ addOverflow};

  always_comb begin
    case (resultSel)
      selAdd:  result = addResult;
      selXor:  result = xorResult;
      selSlt:  result = sltResult;
      selAnd:  result = andResult;
      selOr:   result = orResult;
      default: result = '0;
    endcase
  end

  assign carryOut = addCarry & enableOverflow;     // add and sub only
  assign overflow = addOverflow & enableOverflow;
  assign zero     = ~|result;

  // SUB and XOR give zero exactly when the operands match
  always_comb begin
    if (!$isunknown({cmd, operandA, operandB}) && (cmd == SUB || cmd == XOR)) begin
      assert final (zero == (operandA == operandB))
        else $error("zero flag disagrees with operand compare");
    end
  end

endmodule

// ==== rtl/aluServer.sv ====
`timescale 1ns/1ps

module aluServer import aluPkg::*; import seqPkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             req,
  input  aluCmdT           cmd,
  input  logic [WIDTH-1:0] operandA,
  input  logic [WIDTH-1:0] operandB,
  output logic             ack,
  output logic [WIDTH-1:0] result,
  output logic             carryOut,
  output logic             overflow,
  output logic             zero,
  output aluCmdT           coreCmd,
  output logic [WIDTH-1:0] coreA,
  output logic [WIDTH-1:0] coreB,
  input  logic [WIDTH-1:0] coreResult,
  input  logic             coreCarry,
  input  logic             coreOverflow,
  input  logic             coreZero
);

  serverStateT          state;
  logic [FLAG_BITS-1:0] flagReg;

  assign {carryOut, overflow, zero} = flagReg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= idle;
      ack     <= 1'b0;
      result  <= '0;
      flagReg <= '0;
    end else begin
      case (state)
        idle: begin
          if (req) state <= compute;  // edge k
        end
        compute: begin
          result  <= coreResult;     // edge k+1
          flagReg <= {coreCarry, coreOverflow, coreZero};
          ack     <= 1'b1;
          state   <= done;
        end
        done: begin
          // hold everything until the requester lets go
          if (!req) begin
            ack   <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // operand capture in idle only
  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      coreCmd <= cmd;
      coreA   <= operandA;
      coreB   <= operandB;
    end
  end

  // ack only answers a pending request
  assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
    else $error("ack rose without req");

  // answer stays frozen while ack is held
  assert property (@(posedge clk) disable iff (!rstN)
                   ($past(ack) && ack) |-> ($stable(result) && $stable(flagReg)))
    else $error("result changed while ack was high");

endmodule

// ==== rtl/aluTop.sv ====
`timescale 1ns/1ps

module aluTop import aluPkg::*; #(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             req,
  input  aluCmdT           cmd,
  input  logic [WIDTH-1:0] operandA,
  input  logic [WIDTH-1:0] operandB,
  output logic             ack,
  output logic [WIDTH-1:0] result,
  output logic             carryOut,
  output logic             overflow,
  output logic             zero
);

  aluCmdT           coreCmd;
  logic [WIDTH-1:0] coreA;
  logic [WIDTH-1:0] coreB;
  logic [WIDTH-1:0] coreResult;
  logic             coreCarry;
  logic             coreOverflow;
  logic             coreZero;

  aluServer #(.WIDTH(WIDTH)) server (
    .clk         (clk),
    .rstN        (rstN),
    .req         (req),
    .cmd         (cmd),
    .operandA    (operandA),
    .operandB    (operandB),
    .ack         (ack),
    .result      (result),
    .carryOut    (carryOut),
    .overflow    (overflow),
    .zero        (zero),
    .coreCmd     (coreCmd),
    .coreA       (coreA),
    .coreB       (coreB),
    .coreResult  (coreResult),
    .coreCarry   (coreCarry),
    .coreOverflow(coreOverflow),
    .coreZero    (coreZero)
  );

  aluCore #(.WIDTH(WIDTH)) core (
    .cmd     (coreCmd),
    .operandA(coreA),
    .operandB(coreB),
    .result  (coreResult),
    .carryOut(coreCarry),
    .overflow(coreOverflow),
    .zero    (coreZero)
  );

endmodule

// ==== verif/aluTb.sv ====
`timescale 1ns/1ps

module aluTb import aluPkg::*; ();

  localparam int WIDTH   = DEFAULT_WIDTH;
  localparam int MSB     = WIDTH - 1;
  localparam int TIMEOUT = 20;  // cycles allowed for any single wait

  logic   clk;
  logic   rstN;
  logic   req;
  aluCmdT cmd;
  wordT   operandA;
  wordT   operandB;
  logic   ack;
  wordT   result;
  logic   carryOut;
  logic   overflow;
  logic   zero;

  aluCmdT expCmd;  // request currently being answered
  wordT   expA;
  wordT   expB;
  wordT   edgeVals [0:4];
  int     errors = 0;
  int     checks = 0;
  int     issued = 0;
  int     answered = 0;
  logic   ackSeen = 1'b0;

  aluTop #(.WIDTH(WIDTH)) dut (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .cmd     (cmd),
    .operandA(operandA),
    .operandB(operandB),
    .ack     (ack),
    .result  (result),
    .carryOut(carryOut),
    .overflow(overflow),
    .zero    (zero)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected {result, carryOut, overflow, zero} from the command rules
  function automatic logic [WIDTH+2:0] refModel(aluCmdT c, wordT a, wordT b);
    logic [WIDTH:0] wide;
    wordT           r;
    logic           cy;
    logic           ov;
    wide = '0;
    r    = '0;
    cy   = 1'b0;
    ov   = 1'b0;
    case (c)
      ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[MSB:0];
        cy   = wide[WIDTH];
        ov   = (a[MSB] == b[MSB]) && (r[MSB] != a[MSB]);  // like signs give a flipped sign
      end
      SUB: begin
        wide = {1'b0, a} + {1'b0, ~b} + {{WIDTH{1'b0}}, 1'b1};
        r    = wide[MSB:0];
        cy   = wide[WIDTH];
        ov   = (a[MSB] != b[MSB]) && (r[MSB] != a[MSB]);
      end
      SLT:     r = ($signed(a) < $signed(b)) ? wordT'(1) : wordT'(0);
      XOR:     r = a ^ b;
      AND:     r = a & b;
      NAND:    r = ~(a & b);
      NOR:     r = ~(a | b);
      OR:      r = a | b;
      default: r = '0;
    endcase
    return {r, cy, ov, (r == '0)};
  endfunction

  task automatic compareValue(string name, wordT got, wordT want);
    assert (got === want)
      else begin
        errors++;
        $display("mismatch %s: got %h expected %h (cmd %s a %h b %h)",
                 name, got, want, expCmd.name(), expA, expB);
      end
  endtask

  // checks each cycle with ack high so held answers count too
  always @(negedge clk) begin : compare
    logic [WIDTH+2:0] exp;
    if (rstN) begin
      if (ack && !ackSeen) begin
        answered++;
        assert (req) else begin
          errors++;
          $display("ack rose while req was low");
        end
      end
      if (!ack && ackSeen) begin
        assert (!req) else begin
          errors++;
          $display("ack fell while req was still high");
        end
      end
      if (ack) begin
        exp = refModel(expCmd, expA, expB);
        checks++;
        compareValue("result", result, exp[WIDTH+2:3]);
        compareValue("carryOut", wordT'(carryOut), wordT'(exp[2]));
        compareValue("overflow", wordT'(overflow), wordT'(exp[1]));
        compareValue("zero", wordT'(zero), wordT'(exp[0]));
      end
      ackSeen = ack;
    end
  end

  // four-phase request where extraHold keeps req high past ack
  task automatic runRequest(aluCmdT c, wordT a, wordT b, int extraHold);
    int waited;
    @(posedge clk);
    cmd      <= c;
    operandA <= a;
    operandB <= b;
    req      <= 1'b1;
    expCmd = c;
    expA   = a;
    expB   = b;
    issued++;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < TIMEOUT);
    if (!ack) begin
      errors++;
      $display("timeout: request %0d was never acknowledged", issued);
    end
    repeat (extraHold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (ack && waited < TIMEOUT);
    if (ack) begin
      errors++;
      $display("timeout: ack stayed high after request %0d was released", issued);
    end
  endtask

  initial begin
    wordT rnd;
    int   ci;
    int   i;
    int   j;
    void'($urandom(61));
    rstN     = 1'b0;
    req      = 1'b0;
    cmd      = ADD;
    operandA = '0;
    operandB = '0;
    edgeVals[0] = '0;
    edgeVals[1] = '1;
    edgeVals[2] = {1'b1, {MSB{1'b0}}};  // most negative
    edgeVals[3] = {1'b0, {MSB{1'b1}}};  // most positive
    edgeVals[4] = wordT'(1);
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    // outputs stay cleared until the first request
    repeat (3) begin
      @(negedge clk);
      compareValue("ack", wordT'(ack), '0);
      compareValue("result", result, '0);
      compareValue("carryOut", wordT'(carryOut), '0);
      compareValue("overflow", wordT'(overflow), '0);
      compareValue("zero", wordT'(zero), '0);
    end

    for (ci = 0; ci < 8; ci++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          runRequest(aluCmdT'(ci), edgeVals[i], edgeVals[j], 0);
        end
      end
    end

    // zero flag cases
    rnd = $urandom;
    runRequest(SUB, rnd, rnd, 0);
    runRequest(AND, rnd, ~rnd, 0);
    runRequest(XOR, rnd, rnd, 1);
    runRequest(NOR, rnd, ~rnd, 0);

    // requester holds req well past ack
    runRequest(ADD, $urandom, $urandom, 6);
    runRequest(SLT, $urandom, $urandom, 4);
    runRequest(NAND, $urandom, $urandom, 5);

    repeat (300) begin
      runRequest(aluCmdT'($urandom_range(7, 0)), $urandom, $urandom, $urandom_range(2, 0));
    end

    repeat (2) @(negedge clk);
    assert (answered == issued) else begin
      errors++;
      $display("issued %0d requests but saw %0d answers", issued, answered);
    end

    $display("checks %0d, requests %0d, errors %0d", checks, issued, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/aluPkg.sv
rtl/seqPkg.sv
rtl/aluControl.sv
rtl/rippleAdder.sv
rtl/aluCore.sv
rtl/aluServer.sv
rtl/aluTop.sv
verif/aluTb.sv

// ==== Makefile ====
# Verilator build and run for the ALU request/acknowledge server

VERILATOR ?= verilator
TOP       ?= aluTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
